// ==== verilog/ecc_instr_pkg.sv ====
/*
 * ECC instruction word definitions
 * Field layout, typedefs and ALU opcode codes of the issued instruction
 */
`default_nettype none

package ecc_instr_pkg;

    localparam int INSTR_W = 24;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [7:0]         addr_field_t;
    typedef logic [2:0]         alu_op_t;

    // Bit positions inside an instruction word
    localparam int STALL_BIT  = 23;
    localparam int MODQ_BIT   = 21;   // 0 selects mod p, 1 mod q
    localparam int OP_LSB     = 18;   // Opcode in 20..18
    localparam int WR_A_BIT   = 17;
    localparam int WR_B_BIT   = 16;
    localparam int ADDR_A_LSB = 8;
    localparam int ADDR_B_LSB = 0;

    // Codes seen by the arithmetic units
    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_RED = 3'b010;
    localparam alu_op_t ALU_MUL = 3'b100;

    // Address prefix of the two point slots, bit 2 picks the slot
    localparam logic [4:0] SLOT_REGION = 5'b00001;

endpackage

`default_nettype wire

// ==== verilog/ecc_prog_pkg.sv ====
/*
 * ECC microprogram definitions
 * Program addresses, micro-op codes and the command encoding
 */
`default_nettype none

package ecc_prog_pkg;

    localparam int PROG_ADDR_W = 6;

    typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
    typedef logic [7:0]             uop_t;
    typedef logic [9:0]             mont_cnt_t;

    typedef enum logic [2:0] {
        CMD_IDLE   = 3'd0,
        CMD_KEYGEN = 3'd1,
        CMD_SIGN   = 3'd2,
        CMD_VERIFY = 3'd3
    } ecc_cmd_e;

    // Microprogram map -------------------------------
    localparam prog_addr_t NOP       = 6'd0;
    localparam prog_addr_t PM_INIT_S = 6'd1;
    localparam prog_addr_t PM_INIT_E = 6'd4;
    localparam prog_addr_t PA_S      = 6'd5;   // Point add
    localparam prog_addr_t PA_E      = 6'd14;
    localparam prog_addr_t PD_S      = 6'd15;  // Point double
    localparam prog_addr_t PD_E      = 6'd24;
    localparam prog_addr_t INV_S     = 6'd25;
    localparam prog_addr_t INV_E     = 6'd32;
    localparam prog_addr_t CONV_S    = 6'd33;
    localparam prog_addr_t CONV_E    = 6'd38;
    localparam prog_addr_t SIGN_S    = 6'd39;
    localparam prog_addr_t SIGN_E    = 6'd46;

    // Micro-ops, the upper byte of a program line ----
    localparam uop_t UOP_NOP      = 8'h00;
    localparam uop_t UOP_WR_B     = 8'h01;
    localparam uop_t UOP_WR_A     = 8'h02;
    localparam uop_t UOP_RED_p    = 8'h04;
    localparam uop_t UOP_DO_ADD_p = 8'h08;
    localparam uop_t UOP_DO_SUB_p = 8'h0C;
    localparam uop_t UOP_DO_MUL_p = 8'h10;
    localparam uop_t UOP_RED_q    = 8'h24;
    localparam uop_t UOP_DO_ADD_q = 8'h28;
    localparam uop_t UOP_DO_SUB_q = 8'h2C;
    localparam uop_t UOP_DO_MUL_q = 8'h30;
    localparam uop_t UOP_STALL    = 8'h80;  // Count in low byte

endpackage

`default_nettype wire

// ==== verilog/ecc_sequencer.sv ====
/*
 * ECC microprogram ROM
 * Case-coded program lines with a registered read
 */
`default_nettype none

module ecc_sequencer
    import ecc_instr_pkg::*;
    import ecc_prog_pkg::*;
(
    input  wire        clk,
    input  prog_addr_t addr_i,
    output instr_t     line_o
);

    // Slot addresses 0x08..0x0B all keep bit 2 clear
    always_ff @(posedge clk) begin
        case (addr_i)
            NOP       : line_o <= {UOP_NOP, 8'h00, 8'h00};

            // Ladder init --------------------------------
            PM_INIT_S : line_o <= {UOP_DO_ADD_p, 8'h10, 8'h11};
            6'd2      : line_o <= {UOP_WR_A, 8'h08, 8'h00};
            6'd3      : line_o <= {UOP_DO_MUL_p, 8'h12, 8'h13};
            PM_INIT_E : line_o <= {UOP_WR_B, 8'h00, 8'h0A};

            // Point add ----------------------------------
            PA_S      : line_o <= {UOP_DO_SUB_p, 8'h08, 8'h0A};
            6'd6      : line_o <= {UOP_WR_A, 8'h14, 8'h00};
            6'd7      : line_o <= {UOP_DO_MUL_p, 8'h09, 8'h0B};
            6'd8      : line_o <= {UOP_STALL, 8'h00, 8'h03};
            6'd9      : line_o <= {UOP_WR_B, 8'h00, 8'h15};
            6'd10     : line_o <= {UOP_DO_ADD_p, 8'h14, 8'h15};
            6'd11     : line_o <= {UOP_RED_p, 8'h16, 8'h00};
            6'd12     : line_o <= {UOP_WR_A, 8'h0A, 8'h00};
            6'd13     : line_o <= {UOP_DO_SUB_p, 8'h16, 8'h14};
            PA_E      : line_o <= {UOP_WR_B, 8'h00, 8'h0B};

            // Point double -------------------------------
            PD_S      : line_o <= {UOP_DO_ADD_p, 8'h08, 8'h09};
            6'd16     : line_o <= {UOP_WR_A, 8'h17, 8'h00};
            6'd17     : line_o <= {UOP_DO_MUL_p, 8'h17, 8'h17};
            6'd18     : line_o <= {UOP_STALL, 8'h00, 8'h03};
            6'd19     : line_o <= {UOP_WR_B, 8'h00, 8'h18};
            6'd20     : line_o <= {UOP_DO_SUB_p, 8'h18, 8'h0A};
            6'd21     : line_o <= {UOP_RED_p, 8'h19, 8'h00};
            6'd22     : line_o <= {UOP_WR_A, 8'h08, 8'h00};
            6'd23     : line_o <= {UOP_DO_ADD_p, 8'h19, 8'h0B};
            PD_E      : line_o <= {UOP_WR_B, 8'h00, 8'h09};

            // Inversion
            INV_S     : line_o <= {UOP_DO_MUL_p, 8'h09, 8'h09};
            6'd26     : line_o <= {UOP_WR_A, 8'h20, 8'h00};
            6'd27     : line_o <= {UOP_DO_MUL_p, 8'h20, 8'h09};
            6'd28     : line_o <= {UOP_WR_B, 8'h00, 8'h21};
            6'd29     : line_o <= {UOP_DO_SUB_p, 8'h21, 8'h20};
            6'd30     : line_o <= {UOP_RED_p, 8'h22, 8'h00};
            6'd31     : line_o <= {UOP_DO_MUL_p, 8'h22, 8'h21};
            INV_E     : line_o <= {UOP_WR_A, 8'h23, 8'h00};

            // Affine conversion
            CONV_S    : line_o <= {UOP_DO_MUL_p, 8'h08, 8'h23};
            6'd34     : line_o <= {UOP_WR_A, 8'h24, 8'h00};
            6'd35     : line_o <= {UOP_DO_ADD_p, 8'h24, 8'h25};
            6'd36     : line_o <= {UOP_RED_p, 8'h24, 8'h00};
            6'd37     : line_o <= {UOP_WR_B, 8'h00, 8'h25};
            CONV_E    : line_o <= {UOP_NOP, 8'h00, 8'h00};

            // Signing tail runs mod q --------------------
            SIGN_S    : line_o <= {UOP_DO_MUL_q, 8'h30, 8'h31};
            6'd40     : line_o <= {UOP_WR_A, 8'h32, 8'h00};
            6'd41     : line_o <= {UOP_DO_ADD_q, 8'h32, 8'h24};
            6'd42     : line_o <= {UOP_RED_q, 8'h33, 8'h00};
            6'd43     : line_o <= {UOP_DO_SUB_q, 8'h33, 8'h34};
            6'd44     : line_o <= {UOP_WR_B, 8'h00, 8'h35};
            6'd45     : line_o <= {UOP_DO_MUL_q, 8'h35, 8'h32};
            SIGN_E    : line_o <= {UOP_WR_A, 8'h36, 8'h00};

            default   : line_o <= '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_scalar_reg.sv ====
/*
 * Scalar shift register
 * Hands out one scalar digit per request, most significant first
 */
`default_nettype none

module ecc_scalar_reg #(
    parameter int MONT_COUNT = 384
) (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  load_i,
    input  wire [MONT_COUNT-1:0] scalar_i,
    input  wire                  shift_i,
    output logic                 digit_o
);

    // One spare bit on top, the first request moves the MSB into it
    logic [MONT_COUNT:0] shift_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q <= '0;
        end else if (load_i) begin
            shift_q <= {1'b0, scalar_i};
        end else if (shift_i) begin
            shift_q <= {shift_q[MONT_COUNT-1:0], 1'b0};   // Zero fill
        end
    end

    assign digit_o = shift_q[MONT_COUNT];

endmodule

`default_nettype wire

// ==== verilog/ecc_ctrl.sv ====
/*
 * ECC microcode controller
 * Program counter FSM, stall and latency waits, line pipeline and decode
 */
`default_nettype none

module ecc_ctrl
    import ecc_instr_pkg::*;
    import ecc_prog_pkg::*;
#(
    parameter int MONT_COUNT = 384,
    parameter int MULT_DELAY = 38,
    parameter int ADD_DELAY  = 0
) (
    input  wire        clk,
    input  wire        reset_n,
    input  ecc_cmd_e   ecc_cmd_i,
    input  wire        digit_i,
    output prog_addr_t prog_addr_o,
    input  instr_t     prog_line_i,
    output instr_t     instr_o,
    output logic       req_digit_o,
    output logic       busy_o
);

    prog_addr_t prog_cntr;
    prog_addr_t line_addr;      // Address of the line now at the ROM output
    mont_cnt_t  mont_cntr;
    logic [7:0] stall_cntr;
    logic [7:0] delay_cntr;
    logic       stalled;
    logic       delayed;
    logic       hold;
    logic       start_hold;
    logic       advance;
    logic       delay_op;
    logic       mul_op;
    logic       in_ladder;
    instr_t     prog_line_pipe1;
    instr_t     prog_line_pipe2;
    logic       swap_pipe1;
    logic       swap_pipe2;

    assign prog_addr_o = prog_cntr;
    assign busy_o      = (prog_cntr != NOP);

    always_comb begin
        case (uop_t'(prog_line_i[INSTR_W-1 -: 8]))
            UOP_DO_ADD_p, UOP_DO_SUB_p,
            UOP_DO_ADD_q, UOP_DO_SUB_q : begin delay_op = 1'b1; mul_op = 1'b0; end
            UOP_DO_MUL_p, UOP_DO_MUL_q : begin delay_op = 1'b1; mul_op = 1'b1; end
            default                    : begin delay_op = 1'b0; mul_op = 1'b0; end
        endcase
    end

    assign hold       = stalled | delayed;
    assign start_hold = ~hold & (prog_line_i[STALL_BIT] | delay_op);
    assign advance    = hold ? (stalled ? (stall_cntr == 8'd0) : (delay_cntr == 8'd0))
                             : ~start_hold;

    // Stall and latency waits ------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stalled    <= 1'b0;
            delayed    <= 1'b0;
            stall_cntr <= '0;
            delay_cntr <= '0;
        end else if (stalled) begin
            if (stall_cntr != 8'd0) stall_cntr <= stall_cntr - 8'd1;
            else                    stalled    <= 1'b0;
        end else if (delayed) begin
            if (delay_cntr != 8'd0) delay_cntr <= delay_cntr - 8'd1;
            else                    delayed    <= 1'b0;
        end else if (prog_line_i[STALL_BIT]) begin
            stalled    <= 1'b1;
            stall_cntr <= prog_line_i[7:0];
        end else if (delay_op) begin
            delayed    <= 1'b1;
            delay_cntr <= mul_op ? 8'(MULT_DELAY) : 8'(ADD_DELAY);
        end
    end

    // Program counter FSM ----------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prog_cntr   <= NOP;
            mont_cntr   <= '0;
            req_digit_o <= 1'b0;
        end else begin
            req_digit_o <= 1'b0;    // Pulse only
            if (advance) begin
                case (prog_cntr)
                    NOP : begin
                        case (ecc_cmd_i)
                            CMD_KEYGEN, CMD_SIGN : begin
                                mont_cntr <= mont_cnt_t'(MONT_COUNT);
                                prog_cntr <= PM_INIT_S;
                            end
                            CMD_IDLE, CMD_VERIFY : prog_cntr <= NOP;   // Verify ignored
                            default              : prog_cntr <= NOP;
                        endcase
                    end
                    PM_INIT_E : begin
                        mont_cntr   <= mont_cntr - 1'b1;
                        req_digit_o <= 1'b1;
                        prog_cntr   <= PA_S;
                    end
                    PA_E : prog_cntr <= PD_S;
                    PD_E : begin
                        if (mont_cntr == '0) begin
                            prog_cntr <= INV_S;             // Ladder done
                        end else begin
                            mont_cntr   <= mont_cntr - 1'b1;
                            req_digit_o <= 1'b1;
                            prog_cntr   <= PA_S;
                        end
                    end
                    INV_E  : prog_cntr <= CONV_S;
                    CONV_E : prog_cntr <= (ecc_cmd_i == CMD_SIGN) ? SIGN_S : NOP;
                    SIGN_E : prog_cntr <= NOP;
                    default: prog_cntr <= prog_cntr + 1'b1;
                endcase
            end
        end
    end

    // Line pipeline, each line carries its own swap bit
    assign in_ladder = (line_addr >= PA_S) && (line_addr <= PD_E);

    always_ff @(posedge clk) begin
        line_addr <= prog_cntr;     // Tracks the ROM read
        if (!hold) begin
            prog_line_pipe1 <= prog_line_i;
            swap_pipe1      <= in_ladder & digit_i;
            prog_line_pipe2 <= prog_line_pipe1;
            swap_pipe2      <= swap_pipe1;
        end
    end

    function automatic alu_op_t xlate_op(input logic [2:0] rom_op);
        case (rom_op)
            3'b001  : xlate_op = ALU_RED;
            3'b011  : xlate_op = ALU_SUB;
            3'b100  : xlate_op = ALU_MUL;
            default : xlate_op = ALU_ADD;   // NOP and ADD
        endcase
    endfunction

    function automatic addr_field_t swap_slot(input addr_field_t addr, input logic swap);
        if (addr[7:3] == SLOT_REGION) swap_slot = {addr[7:3], addr[2] ^ swap, addr[1:0]};
        else                          swap_slot = addr;
    endfunction

    // Decode and output register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_o <= '0;
        end else if (hold || prog_line_pipe2[STALL_BIT]) begin
            instr_o <= '0;          // Bubble
        end else begin
            instr_o <= {2'b00,
                        prog_line_pipe2[MODQ_BIT],
                        xlate_op(prog_line_pipe2[OP_LSB +: 3]),
                        prog_line_pipe2[WR_A_BIT],
                        prog_line_pipe2[WR_B_BIT],
                        swap_slot(prog_line_pipe2[ADDR_A_LSB +: 8], swap_pipe2),
                        swap_slot(prog_line_pipe2[ADDR_B_LSB +: 8], swap_pipe2)};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ecc_core_top.sv ====
/*
 * ECC control core
 * Controller, microprogram ROM and scalar register
 */
`default_nettype none

module ecc_core_top
    import ecc_instr_pkg::*;
    import ecc_prog_pkg::*;
#(
    parameter int MONT_COUNT = 384,
    parameter int MULT_DELAY = 38,
    parameter int ADD_DELAY  = 0
) (
    input  wire                  clk,
    input  wire                  reset_n,
    input  ecc_cmd_e             ecc_cmd_i,
    input  wire                  scalar_load_i,
    input  wire [MONT_COUNT-1:0] scalar_i,
    output instr_t               instr_o,
    output logic                 busy_o
);

    prog_addr_t prog_addr;
    instr_t     prog_line;
    logic       req_digit;
    logic       digit;

    ecc_ctrl #(
        .MONT_COUNT (MONT_COUNT),
        .MULT_DELAY (MULT_DELAY),
        .ADD_DELAY  (ADD_DELAY)
    ) i_ecc_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .ecc_cmd_i   (ecc_cmd_i),
        .digit_i     (digit),
        .prog_addr_o (prog_addr),
        .prog_line_i (prog_line),
        .instr_o     (instr_o),
        .req_digit_o (req_digit),
        .busy_o      (busy_o)
    );

    ecc_sequencer i_ecc_sequencer (
        .clk    (clk),
        .addr_i (prog_addr),
        .line_o (prog_line)
    );

    ecc_scalar_reg #(
        .MONT_COUNT (MONT_COUNT)
    ) i_ecc_scalar_reg (
        .clk      (clk),
        .reset_n  (reset_n),
        .load_i   (scalar_load_i),
        .scalar_i (scalar_i),
        .shift_i  (req_digit),
        .digit_o  (digit)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock and reset generator
 */
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released just after a rising edge
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_ecc_core.sv ====
/*
 * ECC control core testbench
 * Table of idle, keygen and sign runs with ladder round and slot swap checks
 */
`default_nettype none

module tb_ecc_core
    import ecc_instr_pkg::*;
    import ecc_prog_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MONT_COUNT   = 8;
    localparam int MULT_DELAY   = 6;
    localparam int ADD_DELAY    = 1;
    localparam int CLK_PERIOD   = 20;
    localparam int NUM_TESTS    = 8;
    localparam int IDLE_CYCLES  = 50;
    localparam int FLUSH_CYCLES = 6;
    localparam int START_LIMIT  = 4;
    localparam int RAND_SEED    = 37054;
    // Worst case per line is the longest wait plus pipeline slack
    localparam int LINE_CYCLES  = MULT_DELAY + ADD_DELAY + 8;
    localparam int RUN_CYCLES   = (int'(SIGN_E) + 1 + MONT_COUNT * (int'(PD_E) - int'(PA_S) + 1))
                                  * LINE_CYCLES + IDLE_CYCLES + FLUSH_CYCLES;

    logic                  clk;
    logic                  reset_n;
    ecc_cmd_e              ecc_cmd;
    logic                  scalar_load;
    logic [MONT_COUNT-1:0] scalar;
    instr_t                instr;
    logic                  busy;

    // Stimulus table --------------------------------
    string                 test_name   [NUM_TESTS];
    logic [MONT_COUNT-1:0] test_scalar [NUM_TESTS];
    ecc_cmd_e              test_cmd    [NUM_TESTS];
    int                    test_rounds [NUM_TESTS];

    int                    value_errors;
    int                    other_errors;
    int                    rounds_seen;
    logic                  ladder_on;
    int                    busy_cycles;
    int                    keygen_cycles;
    logic [MONT_COUNT-1:0] keygen_scalar;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) i_tb_clock (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    ecc_core_top #(
        .MONT_COUNT (MONT_COUNT),
        .MULT_DELAY (MULT_DELAY),
        .ADD_DELAY  (ADD_DELAY)
    ) i_ecc_core_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .ecc_cmd_i     (ecc_cmd),
        .scalar_load_i (scalar_load),
        .scalar_i      (scalar),
        .instr_o       (instr),
        .busy_o        (busy)
    );

    // Compare tasks ---------------------------------
    task automatic check_instr(input string name, input instr_t exp, input instr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %06h, actual %06h", name, exp, act);
        end
    endtask

    task automatic check_op_legal(input string name, input alu_op_t act);
        if (!(act inside {ALU_ADD, ALU_SUB, ALU_RED, ALU_MUL})) begin
            value_errors++;
            $display("Fail %s opcode: expected 000, 001, 010 or 100, actual %03b", name, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic logic is_slot(input addr_field_t addr);
        return addr[7:3] == SLOT_REGION;
    endfunction

    function automatic logic [MONT_COUNT-1:0] random_scalar();
        logic [MONT_COUNT+31:0] acc;
        acc = '0;
        for (int i = 0; i < MONT_COUNT; i += 32) begin
            acc = {acc[MONT_COUNT-1:0], $urandom()};
        end
        return acc[MONT_COUNT-1:0];
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [MONT_COUNT-1:0] value,
                             input ecc_cmd_e cmd, input int rounds);
        test_name[idx]   = name;
        test_scalar[idx] = value;
        test_cmd[idx]    = cmd;
        test_rounds[idx] = rounds;
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;                 // Sample and drive point
    endtask

    // Checks one issued instruction and tracks ladder rounds
    task automatic inspect_instr(input int idx);
        alu_op_t     op;
        addr_field_t addr_a;
        addr_field_t addr_b;
        logic        exp_slot;
        op     = instr[OP_LSB +: 3];
        addr_a = instr[ADDR_A_LSB +: 8];
        addr_b = instr[ADDR_B_LSB +: 8];
        check_bit({test_name[idx], " bit 23"}, 1'b0, instr[23]);
        check_bit({test_name[idx], " bit 22"}, 1'b0, instr[22]);
        check_op_legal(test_name[idx], op);
        // Point add opens with SUB on slots 0x08 and 0x0A
        if (!ladder_on && rounds_seen == 0 && op == ALU_SUB && is_slot(addr_a) && is_slot(addr_b)
                && addr_a[1:0] == 2'b00 && addr_b[1:0] == 2'b10) begin
            ladder_on = 1'b1;
        end
        exp_slot = ladder_on ? test_scalar[idx][MONT_COUNT-1-rounds_seen] : 1'b0;
        if (is_slot(addr_a)) check_bit($sformatf("%s slot A r%0d", test_name[idx], rounds_seen),
                                       exp_slot, addr_a[2]);
        if (is_slot(addr_b)) check_bit($sformatf("%s slot B r%0d", test_name[idx], rounds_seen),
                                       exp_slot, addr_b[2]);
        // Last point double line writes B of slot 0x09, extra rounds count too
        if (instr[WR_B_BIT] && !instr[WR_A_BIT] && addr_a == 8'h00
                && is_slot(addr_b) && addr_b[1:0] == 2'b01) begin
            rounds_seen++;
            ladder_on = ladder_on && (rounds_seen < MONT_COUNT);
        end
    endtask

    task automatic run_entry(input int idx);
        int cycles;
        rounds_seen = 0;
        ladder_on   = 1'b0;
        busy_cycles = 0;
        cycles      = 0;
        scalar      = test_scalar[idx];
        scalar_load = 1'b1;
        step_cycle();
        scalar_load = 1'b0;
        ecc_cmd     = test_cmd[idx];
        if (test_rounds[idx] == 0) begin
            repeat (IDLE_CYCLES) begin
                step_cycle();
                check_bit({test_name[idx], " busy"}, 1'b0, busy);
                check_instr({test_name[idx], " instr"}, '0, instr);
            end
        end else begin
            while (!busy && cycles < START_LIMIT) begin
                step_cycle();
                cycles++;
            end
            if (!busy) begin
                other_errors++;
                $display("%s: busy did not rise after the command", test_name[idx]);
            end
            while (busy && busy_cycles < RUN_CYCLES) begin
                inspect_instr(idx);
                busy_cycles++;
                step_cycle();
            end
            if (busy) begin
                other_errors++;
                $display("%s: busy still high after %0d cycles", test_name[idx], busy_cycles);
            end
            ecc_cmd = CMD_IDLE;     // Before the controller samples it at NOP
            repeat (FLUSH_CYCLES) begin
                inspect_instr(idx);
                step_cycle();
            end
            check_count({test_name[idx], " rounds"}, test_rounds[idx], rounds_seen);
            if (test_cmd[idx] == CMD_KEYGEN) begin
                keygen_cycles = busy_cycles;
                keygen_scalar = test_scalar[idx];
            end else if (test_scalar[idx] == keygen_scalar && busy_cycles <= keygen_cycles) begin
                other_errors++;
                $display("%s: sign run of %0d cycles is not longer than keygen run of %0d",
                         test_name[idx], busy_cycles, keygen_cycles);
            end
        end
        ecc_cmd = CMD_IDLE;
    endtask

    initial begin
        ecc_cmd       = CMD_IDLE;
        scalar_load   = 1'b0;
        scalar        = '0;
        value_errors  = 0;
        other_errors  = 0;
        keygen_cycles = 0;
        keygen_scalar = '0;
        void'($urandom(RAND_SEED));
        set_entry(0, "idle_hold", 8'hA5, CMD_IDLE, 0);
        set_entry(1, "verify_ignored", 8'h3C, CMD_VERIFY, 0);
        set_entry(2, "keygen_a5", 8'hA5, CMD_KEYGEN, MONT_COUNT);
        set_entry(3, "sign_a5", 8'hA5, CMD_SIGN, MONT_COUNT);
        set_entry(4, "keygen_random", random_scalar(), CMD_KEYGEN, MONT_COUNT);
        set_entry(5, "sign_random", test_scalar[4], CMD_SIGN, MONT_COUNT);
        set_entry(6, "keygen_ones", 8'hFF, CMD_KEYGEN, MONT_COUNT);
        set_entry(7, "keygen_zero", 8'h00, CMD_KEYGEN, MONT_COUNT);
        @(posedge reset_n);
        repeat (4) begin
            step_cycle();
            check_bit("reset busy", 1'b0, busy);
            check_instr("reset instr", '0, instr);
        end
        for (int idx = 0; idx < NUM_TESTS; idx++) begin
            run_entry(idx);
        end
        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_TESTS * RUN_CYCLES + 24) * CLK_PERIOD);
        $display("Watchdog: the run did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/ecc_instr_pkg.sv
verilog/ecc_prog_pkg.sv
verilog/ecc_sequencer.sv
verilog/ecc_scalar_reg.sv
verilog/ecc_ctrl.sv
verilog/ecc_core_top.sv
bench/tb_clock.sv
bench/tb_ecc_core.sv

// ==== Makefile ====
# Verilator build and run of the ECC control core testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
